// File: verilog/arith_rs_pkg.sv
// Widths, depth, entry state type and port structs of the arithmetic reservation station
package arith_rs_pkg;

    // --------------------------------------------------------------------------
    // Widths and depth
    // --------------------------------------------------------------------------
    localparam int XLEN        = 32;                // Operand and result width
    localparam int ROB_IDX_LEN = 4;                 // ROB tag width
    localparam int EU_CTL_LEN  = 4;                 // Execution unit control width
    localparam int EXCEPT_LEN  = 4;                 // Exception code width
    localparam int RS_DEPTH    = 4;                 // Number of entries
    localparam int RS_IDX_LEN  = $clog2(RS_DEPTH);

    // Entry FSM states
    typedef enum logic [2:0] {
        EMPTY,
        RS12_PENDING,   // Both operands missing
        RS1_PENDING,
        RS2_PENDING,
        EX_REQ,         // Operands complete, request raised
        EX_WAIT,        // Accepted by the execution unit
        COMPLETED       // Result held until the CDB takes it
    } rs_state_t;

    // --------------------------------------------------------------------------
    // Port words
    // --------------------------------------------------------------------------

    // Operand from the issue stage
    typedef struct packed {
        logic                   ready;      // Value already known
        logic [ROB_IDX_LEN-1:0] rob_idx;    // Producer tag when not ready
        logic [XLEN-1:0]        value;
    } op_data_t;

    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] rob_idx;
        logic [XLEN-1:0]        res_value;
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } cdb_data_t;

    // Request to the execution unit
    typedef struct packed {
        logic [EU_CTL_LEN-1:0]  eu_ctl;
        logic [XLEN-1:0]        rs1_value;
        logic [XLEN-1:0]        rs2_value;
        logic [ROB_IDX_LEN-1:0] rob_idx;    // Destination tag
    } eu_req_t;

    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] rob_idx;
        logic [XLEN-1:0]        result;
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } eu_res_t;

endpackage

// File: verilog/prio_enc.sv
// Priority encoder returning the lowest set request line
`timescale 1ns/1ns

module prio_enc #(
    parameter int N = 4
) (
    input  logic [N-1:0]                       lines_i,
    output logic [$clog2((N > 1) ? N : 2)-1:0] idx_o,
    output logic                               valid_o
);

    typedef logic [$clog2((N > 1) ? N : 2)-1:0] idx_t;

    // Scan downwards so the lowest set line is written last
    always_comb begin
        idx_o   = '0;
        valid_o = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                idx_o   = idx_t'(i);
                valid_o = 1'b1;
            end
        end
    end

endmodule

// File: verilog/rs_entry.sv
// Single reservation station entry with its FSM, operand forwarding and stored fields
`timescale 1ns/1ns

module rs_entry (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                insert_i,
    input  logic [arith_rs_pkg::EU_CTL_LEN-1:0]  issue_ctl_i,
    input  arith_rs_pkg::op_data_t              issue_rs1_i,
    input  arith_rs_pkg::op_data_t              issue_rs2_i,
    input  logic [arith_rs_pkg::ROB_IDX_LEN-1:0] issue_dest_i,
    input  logic                                eu_res_valid_i,
    input  arith_rs_pkg::eu_res_t               eu_res_i,
    input  logic                                cdb_valid_i,
    input  arith_rs_pkg::cdb_data_t             cdb_data_i,
    input  logic                                dispatch_i,
    input  logic                                retire_i,
    output arith_rs_pkg::rs_state_t             state_o,
    output arith_rs_pkg::eu_req_t               req_o,
    output arith_rs_pkg::cdb_data_t             cdb_o
);

    import arith_rs_pkg::*;

    // Update applied to the stored fields this cycle
    typedef enum logic [2:0] {
        OP_NONE,
        OP_INSERT,
        OP_SAVE_RS1,
        OP_SAVE_RS2,
        OP_SAVE_RS12,
        OP_SAVE_RES
    } op_t;

    rs_state_t              state_q, state_d;
    op_t                    op;

    eu_req_t                req_q;                  // Control, operand values, destination
    eu_res_t                res_q;                  // Result and exception from the EU
    logic [ROB_IDX_LEN-1:0] rs1_tag_q, rs2_tag_q;   // Producer tags of pending operands

    logic                   ins_fwd_rs1, ins_fwd_rs2;
    logic                   rs1_miss, rs2_miss;
    logic [XLEN-1:0]        ins_rs1_val, ins_rs2_val;
    logic                   fwd_rs1_eu, fwd_rs2_eu;
    logic                   fwd_rs1, fwd_rs2;
    logic                   res_hit;

    // --------------------------------------------------------------------------
    // Tag comparison
    // --------------------------------------------------------------------------
    always_comb begin
        // Forwarding in the insert cycle comes only from the execution unit
        ins_fwd_rs1 = eu_res_valid_i && (eu_res_i.rob_idx == issue_rs1_i.rob_idx);
        ins_fwd_rs2 = eu_res_valid_i && (eu_res_i.rob_idx == issue_rs2_i.rob_idx);
        rs1_miss    = !issue_rs1_i.ready && !ins_fwd_rs1;
        rs2_miss    = !issue_rs2_i.ready && !ins_fwd_rs2;
        ins_rs1_val = issue_rs1_i.ready ? issue_rs1_i.value : eu_res_i.result;
        ins_rs2_val = issue_rs2_i.ready ? issue_rs2_i.value : eu_res_i.result;

        // Pending operands listen to both the EU and the CDB
        fwd_rs1_eu  = eu_res_valid_i && (eu_res_i.rob_idx == rs1_tag_q);
        fwd_rs2_eu  = eu_res_valid_i && (eu_res_i.rob_idx == rs2_tag_q);
        fwd_rs1     = fwd_rs1_eu || (cdb_valid_i && (cdb_data_i.rob_idx == rs1_tag_q));
        fwd_rs2     = fwd_rs2_eu || (cdb_valid_i && (cdb_data_i.rob_idx == rs2_tag_q));

        res_hit     = eu_res_valid_i && (eu_res_i.rob_idx == req_q.rob_idx);
    end

    // --------------------------------------------------------------------------
    // Entry FSM
    // --------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        op      = OP_NONE;
        case (state_q)
            EMPTY: begin
                if (insert_i) begin
                    op = OP_INSERT;
                    if (rs1_miss && rs2_miss) begin
                        state_d = RS12_PENDING;
                    end else if (rs1_miss) begin
                        state_d = RS1_PENDING;
                    end else if (rs2_miss) begin
                        state_d = RS2_PENDING;
                    end else begin
                        state_d = EX_REQ;
                    end
                end
            end
            RS12_PENDING: begin
                if (fwd_rs1 && fwd_rs2) begin
                    op      = OP_SAVE_RS12;
                    state_d = EX_REQ;
                end else if (fwd_rs1) begin
                    op      = OP_SAVE_RS1;
                    state_d = RS2_PENDING;
                end else if (fwd_rs2) begin
                    op      = OP_SAVE_RS2;
                    state_d = RS1_PENDING;
                end
            end
            RS1_PENDING: begin
                if (fwd_rs1) begin
                    op      = OP_SAVE_RS1;
                    state_d = EX_REQ;
                end
            end
            RS2_PENDING: begin
                if (fwd_rs2) begin
                    op      = OP_SAVE_RS2;
                    state_d = EX_REQ;
                end
            end
            EX_REQ: begin
                if (res_hit) begin              // Result may overtake the acceptance
                    op      = OP_SAVE_RES;
                    state_d = COMPLETED;
                end else if (dispatch_i) begin
                    state_d = EX_WAIT;
                end
            end
            EX_WAIT: begin
                if (res_hit) begin
                    op      = OP_SAVE_RES;
                    state_d = COMPLETED;
                end
            end
            COMPLETED: begin
                if (retire_i) begin
                    state_d = EMPTY;
                end
            end
            default: state_d = EMPTY;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMPTY;
        end else if (flush_i) begin
            state_q <= EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------------------------------
    // Stored fields
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (op)
            OP_INSERT: begin
                req_q.eu_ctl    <= issue_ctl_i;
                req_q.rs1_value <= ins_rs1_val;
                req_q.rs2_value <= ins_rs2_val;
                req_q.rob_idx   <= issue_dest_i;
                rs1_tag_q       <= issue_rs1_i.rob_idx;
                rs2_tag_q       <= issue_rs2_i.rob_idx;
            end
            OP_SAVE_RS1: begin
                req_q.rs1_value <= fwd_rs1_eu ? eu_res_i.result : cdb_data_i.res_value;
            end
            OP_SAVE_RS2: begin
                req_q.rs2_value <= fwd_rs2_eu ? eu_res_i.result : cdb_data_i.res_value;
            end
            OP_SAVE_RS12: begin
                req_q.rs1_value <= fwd_rs1_eu ? eu_res_i.result : cdb_data_i.res_value;
                req_q.rs2_value <= fwd_rs2_eu ? eu_res_i.result : cdb_data_i.res_value;
            end
            OP_SAVE_RES: res_q <= eu_res_i;     // Tag equals the destination
            default: ;
        endcase
    end

    assign state_o             = state_q;
    assign req_o               = req_q;
    assign cdb_o.rob_idx       = res_q.rob_idx;
    assign cdb_o.res_value     = res_q.result;
    assign cdb_o.except_raised = res_q.except_raised;
    assign cdb_o.except_code   = res_q.except_code;

endmodule

// File: verilog/arith_rs.sv
// Arithmetic reservation station top level with entries, selectors and output muxes
`timescale 1ns/1ns

module arith_rs (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // Issue stage
    input  logic                                issue_valid_i,
    output logic                                issue_ready_o,
    input  logic [arith_rs_pkg::EU_CTL_LEN-1:0]  issue_ctl_i,
    input  arith_rs_pkg::op_data_t              issue_rs1_i,
    input  arith_rs_pkg::op_data_t              issue_rs2_i,
    input  logic [arith_rs_pkg::ROB_IDX_LEN-1:0] issue_dest_i,

    // Execution unit
    input  logic                                eu_ready_i,
    output logic                                eu_valid_o,
    output arith_rs_pkg::eu_req_t               eu_req_o,
    input  logic                                eu_valid_i,     // Results are always accepted
    input  arith_rs_pkg::eu_res_t               eu_res_i,

    // Common data bus
    input  logic                                cdb_valid_i,
    input  arith_rs_pkg::cdb_data_t             cdb_data_i,
    input  logic                                cdb_ready_i,
    output logic                                cdb_valid_o,
    output arith_rs_pkg::cdb_data_t             cdb_data_o
);

    import arith_rs_pkg::*;

    rs_state_t             state [RS_DEPTH];
    eu_req_t               req_w [RS_DEPTH];
    cdb_data_t             cdb_w [RS_DEPTH];

    logic [RS_DEPTH-1:0]   empty_vec, ex_vec, cdb_vec;  // Selector request lines
    logic [RS_IDX_LEN-1:0] new_idx, ex_idx, cdb_idx;
    logic                  new_vld, ex_vld, cdb_vld;
    logic                  insert, dispatch, retire;

    logic                  ex_hold_q, cdb_hold_q;       // Offer stalled in the last cycle
    logic [RS_IDX_LEN-1:0] ex_hold_idx_q, cdb_hold_idx_q;
    logic [RS_IDX_LEN-1:0] ex_pick, cdb_pick;           // Entry actually offered
    logic                  ex_ok;

    // --------------------------------------------------------------------------
    // Handshake strobes
    // --------------------------------------------------------------------------
    assign insert   = issue_valid_i && new_vld;
    assign dispatch = ex_ok && eu_ready_i;
    assign retire   = cdb_vld && cdb_ready_i;

    // --------------------------------------------------------------------------
    // Entries
    // --------------------------------------------------------------------------
    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_entry
        rs_entry u_entry (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .flush_i        (flush_i),
            .insert_i       (insert && (new_idx == RS_IDX_LEN'(g))),
            .issue_ctl_i    (issue_ctl_i),
            .issue_rs1_i    (issue_rs1_i),
            .issue_rs2_i    (issue_rs2_i),
            .issue_dest_i   (issue_dest_i),
            .eu_res_valid_i (eu_valid_i),
            .eu_res_i       (eu_res_i),
            .cdb_valid_i    (cdb_valid_i),
            .cdb_data_i     (cdb_data_i),
            .dispatch_i     (dispatch && (ex_pick == RS_IDX_LEN'(g))),
            .retire_i       (retire && (cdb_pick == RS_IDX_LEN'(g))),
            .state_o        (state[g]),
            .req_o          (req_w[g]),
            .cdb_o          (cdb_w[g])
        );

        assign empty_vec[g] = (state[g] == EMPTY);
        assign ex_vec[g]    = (state[g] == EX_REQ);
        assign cdb_vec[g]   = (state[g] == COMPLETED);
    end

    // --------------------------------------------------------------------------
    // Entry selectors
    // --------------------------------------------------------------------------
    prio_enc #(.N(RS_DEPTH)) new_sel (     // Lowest free entry
        .lines_i (empty_vec),
        .idx_o   (new_idx),
        .valid_o (new_vld)
    );

    prio_enc #(.N(RS_DEPTH)) ex_sel (      // Lowest entry ready to execute
        .lines_i (ex_vec),
        .idx_o   (ex_idx),
        .valid_o (ex_vld)
    );

    prio_enc #(.N(RS_DEPTH)) cdb_sel (     // Lowest completed entry
        .lines_i (cdb_vec),
        .idx_o   (cdb_idx),
        .valid_o (cdb_vld)
    );

    // --------------------------------------------------------------------------
    // Stalled offers keep their entry until taken
    // --------------------------------------------------------------------------
    assign ex_pick  = ex_hold_q ? ex_hold_idx_q : ex_idx;
    assign cdb_pick = cdb_hold_q ? cdb_hold_idx_q : cdb_idx;
    assign ex_ok    = ex_hold_q ? ex_vec[ex_hold_idx_q] : ex_vld;  // Drops if the result overtakes

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_hold_q      <= 1'b0;
            cdb_hold_q     <= 1'b0;
            ex_hold_idx_q  <= '0;
            cdb_hold_idx_q <= '0;
        end else if (flush_i) begin
            ex_hold_q  <= 1'b0;
            cdb_hold_q <= 1'b0;
        end else begin
            ex_hold_q      <= ex_ok && !eu_ready_i;
            cdb_hold_q     <= cdb_vld && !cdb_ready_i;
            ex_hold_idx_q  <= ex_pick;
            cdb_hold_idx_q <= cdb_pick;
        end
    end

    // Outputs follow the selected entries
    assign issue_ready_o = new_vld;
    assign eu_valid_o    = ex_ok;
    assign eu_req_o      = req_w[ex_pick];
    assign cdb_valid_o   = cdb_vld;
    assign cdb_data_o    = cdb_w[cdb_pick];

endmodule

// File: sim/arith_rs_props.sv
// Concurrent assertions on the reservation station handshakes, bound to the top level
`timescale 1ns/1ns

module arith_rs_props (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    issue_ready_o,
    input  logic                    eu_valid_o,
    input  logic                    eu_ready_i,
    input  arith_rs_pkg::eu_req_t   eu_req_o,
    input  logic                    eu_valid_i,
    input  arith_rs_pkg::eu_res_t   eu_res_i,
    input  logic                    cdb_valid_o,
    input  logic                    cdb_ready_i,
    input  arith_rs_pkg::cdb_data_t cdb_data_o
);

    logic own_res;  // Result for the requesting entry arrives now

    assign own_res = eu_valid_i && (eu_res_i.rob_idx == eu_req_o.rob_idx);

    // ------------------------------------------------------------------------
    // Execution unit request
    // ------------------------------------------------------------------------
    a_eu_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        eu_valid_o && !eu_ready_i && !own_res && !flush_i |=> eu_valid_o
    ) else $error("eu_valid_o dropped before acceptance");

    // CDB word under back-pressure
    a_cdb_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o && !cdb_ready_i && !flush_i |=> cdb_valid_o && $stable(cdb_data_o)
    ) else $error("cdb_data_o changed while stalled");

    a_no_x: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown({eu_valid_o, cdb_valid_o, issue_ready_o})
    ) else $error("Unknown value on a valid output");

endmodule

// File: sim/tb_arith_rs.sv
// Testbench for the arithmetic reservation station with random stimulus, model and checks
`timescale 1ns/1ns

module tb_arith_rs;

    import arith_rs_pkg::*;

    localparam int NUM_OPS        = 300;
    localparam int SEED           = 51805;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 400 + 8;
    localparam int NUM_TAGS       = 1 << ROB_IDX_LEN;
    localparam int EXT_BASE       = 8;              // Tags 8..15 belong to other units

    logic                   clk_i, rst_n_i, flush_i;
    logic                   issue_valid_i, issue_ready_o;
    logic [EU_CTL_LEN-1:0]  issue_ctl_i;
    op_data_t               issue_rs1_i, issue_rs2_i;
    logic [ROB_IDX_LEN-1:0] issue_dest_i;
    logic                   eu_ready_i, eu_valid_o, eu_valid_i;
    eu_req_t                eu_req_o;
    eu_res_t                eu_res_i;
    logic                   cdb_valid_i, cdb_ready_i, cdb_valid_o;
    cdb_data_t              cdb_data_i, cdb_data_o;

    integer seed = SEED;
    int     cycle, issued, n_chk [1:6], n_err [1:6];
    bit     flush_now, flushed, prev_flush, prev_hold;
    cdb_data_t prev_data;

    // Reference model, indexed by ROB tag
    bit              in_flight [NUM_TAGS], dispatched [NUM_TAGS], answered [NUM_TAGS];
    bit              ext_pend [NUM_TAGS];
    logic [3:0]      ctl_m [NUM_TAGS];
    bit              op_known [NUM_TAGS][2];
    logic [3:0]      op_dep [NUM_TAGS][2];
    logic [31:0]     op_val [NUM_TAGS][2];
    logic [31:0]     res_val [NUM_TAGS];
    bit              res_exc [NUM_TAGS];
    logic [3:0]      res_code [NUM_TAGS];
    int              eu_tag_q [$], eu_due_q [$];   // Execution unit pipeline

    arith_rs dut_i (.*);

    bind arith_rs arith_rs_props u_props (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .issue_ready_o (issue_ready_o), .eu_valid_o (eu_valid_o), .eu_ready_i (eu_ready_i),
        .eu_req_o (eu_req_o), .eu_valid_i (eu_valid_i), .eu_res_i (eu_res_i),
        .cdb_valid_o (cdb_valid_o), .cdb_ready_i (cdb_ready_i), .cdb_data_o (cdb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic int urand(int n);
        urand = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int count_in_flight();
        int cnt;
        cnt = 0;
        for (int i = 0; i < EXT_BASE; i++) begin
            cnt += int'(in_flight[i]);
        end
        return cnt;
    endfunction

    task automatic cmp(int b, string name, logic [31:0] got, logic [31:0] exp);
        n_chk[b]++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            n_err[b]++;
        end
    endtask

    task automatic report_failure(int b, string what);
        n_err[b]++;
        $display("%0t: %s", $time, what);
    endtask

    // Operand is ready, waits on a station tag, or waits on another unit's tag
    task automatic make_operand(output op_data_t op, input int cur_cdb);
        int cand [$];
        int t;
        op.ready   = 1'b1;
        op.rob_idx = 4'(urand(NUM_TAGS));
        op.value   = $random(seed);
        if (urand(2) == 0) begin
            if (urand(2) == 0) begin
                for (int i = 0; i < EXT_BASE; i++) begin
                    if (in_flight[i] && !answered[i]) cand.push_back(i);
                end
                if (cand.size() > 0) begin
                    op.ready   = 1'b0;
                    op.rob_idx = 4'(cand[urand(cand.size())]);
                end
            end else begin
                t = EXT_BASE + urand(NUM_TAGS - EXT_BASE);
                if (t != cur_cdb) begin     // Same-cycle CDB value would be missed
                    op.ready   = 1'b0;
                    op.rob_idx = 4'(t);
                end
            end
        end
    endtask

    task automatic resolve(int tag, logic [31:0] value);
        for (int t = 0; t < EXT_BASE; t++) begin
            for (int k = 0; k < 2; k++) begin
                if (in_flight[t] && !op_known[t][k] && op_dep[t][k] == 4'(tag)) begin
                    op_known[t][k] = 1'b1;
                    op_val[t][k]   = value;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus driven 2 ns after the rising edge
    // ------------------------------------------------------------------------
    task automatic drive_inputs();
        int cand [$];
        int t;
        int cur_cdb;
        cur_cdb       = -1;
        flush_i       = flush_now;
        issue_valid_i = 1'b0;
        eu_valid_i    = 1'b0;
        eu_res_i      = '0;
        cdb_valid_i   = 1'b0;
        cdb_data_i    = '0;
        eu_ready_i    = (urand(10) < 7);
        cdb_ready_i   = (urand(10) < 6);
        if (flush_now) begin
            flush_now = 1'b0;
            return;
        end
        for (int k = 0; k < eu_tag_q.size(); k++) begin
            if (eu_due_q[k] <= cycle) begin
                t                      = eu_tag_q[k];
                eu_valid_i             = 1'b1;
                eu_res_i.rob_idx       = 4'(t);
                eu_res_i.result        = res_val[t];
                eu_res_i.except_raised = res_exc[t];
                eu_res_i.except_code   = res_code[t];
                eu_tag_q.delete(k);
                eu_due_q.delete(k);
                break;
            end
        end
        for (int i = EXT_BASE; i < NUM_TAGS; i++) begin
            if (ext_pend[i]) cand.push_back(i);
        end
        if (cand.size() > 0 && urand(10) < 3) begin
            cur_cdb                  = cand[urand(cand.size())];
            cdb_valid_i              = 1'b1;
            cdb_data_i.rob_idx       = 4'(cur_cdb);
            cdb_data_i.res_value     = $random(seed);
            cdb_data_i.except_raised = 1'(urand(2));
            cdb_data_i.except_code   = 4'(urand(16));
        end
        cand.delete();
        if (issued < NUM_OPS && urand(10) < 8) begin
            for (int i = 0; i < EXT_BASE; i++) begin
                if (!in_flight[i]) cand.push_back(i);
            end
            issue_valid_i = 1'b1;
            issue_dest_i  = 4'(cand[urand(cand.size())]);
            issue_ctl_i   = 4'(urand(16));
            make_operand(issue_rs1_i, cur_cdb);
            make_operand(issue_rs2_i, cur_cdb);
        end
    endtask

    // ------------------------------------------------------------------------
    // Checks and model update at the falling edge where outputs are stable
    // ------------------------------------------------------------------------
    task automatic observe();
        int t;
        op_data_t op;
        cmp(4, "issue_ready_o", 32'(issue_ready_o), 32'(count_in_flight() != RS_DEPTH));
        if (prev_hold) begin
            cmp(5, "cdb_valid_o", 32'(cdb_valid_o), 32'd1);
            cmp(5, "cdb_data_o.rob_idx", 32'(cdb_data_o.rob_idx), 32'(prev_data.rob_idx));
            cmp(5, "cdb_data_o.res_value", cdb_data_o.res_value, prev_data.res_value);
            cmp(5, "cdb_data_o.except_raised", 32'(cdb_data_o.except_raised),
                32'(prev_data.except_raised));
            cmp(5, "cdb_data_o.except_code", 32'(cdb_data_o.except_code),
                32'(prev_data.except_code));
        end
        if (prev_flush) begin
            cmp(6, "eu_valid_o", 32'(eu_valid_o), 32'd0);
            cmp(6, "cdb_valid_o", 32'(cdb_valid_o), 32'd0);
            cmp(6, "issue_ready_o", 32'(issue_ready_o), 32'd1);
        end
        prev_flush = flush_i;
        prev_hold  = cdb_valid_o && !cdb_ready_i && !flush_i;
        prev_data  = cdb_data_o;
        if (flush_i) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                in_flight[i] = 1'b0;
                ext_pend[i]  = 1'b0;
            end
            eu_tag_q.delete();
            eu_due_q.delete();
            return;
        end
        if (issue_valid_i && issue_ready_o) begin
            t             = int'(issue_dest_i);
            in_flight[t]  = 1'b1;
            dispatched[t] = 1'b0;
            answered[t]   = 1'b0;
            ctl_m[t]      = issue_ctl_i;
            issued++;
            for (int k = 0; k < 2; k++) begin
                op             = (k == 0) ? issue_rs1_i : issue_rs2_i;
                op_known[t][k] = op.ready;
                op_val[t][k]   = op.value;
                op_dep[t][k]   = op.rob_idx;
                if (!op.ready && int'(op.rob_idx) >= EXT_BASE) ext_pend[op.rob_idx] = 1'b1;
            end
        end
        if (eu_valid_o && eu_ready_i) begin
            t = int'(eu_req_o.rob_idx);
            n_chk[2]++;
            if (!in_flight[t] || dispatched[t]) begin
                report_failure(2, "dispatch of a tag that is not waiting for execution");
            end else if (!op_known[t][0] || !op_known[t][1]) begin
                report_failure(2, "dispatch before the model has both operand values");
            end else begin
                cmp(2, "eu_req_o.rs1_value", eu_req_o.rs1_value, op_val[t][0]);
                cmp(2, "eu_req_o.rs2_value", eu_req_o.rs2_value, op_val[t][1]);
                cmp(2, "eu_req_o.eu_ctl", 32'(eu_req_o.eu_ctl), 32'(ctl_m[t]));
                dispatched[t] = 1'b1;
                res_val[t]    = op_val[t][0] + (op_val[t][1] ^ 32'(ctl_m[t]));
                res_exc[t]    = 1'(urand(2));
                res_code[t]   = 4'(urand(16));
                eu_tag_q.push_back(t);
                eu_due_q.push_back(cycle + 1 + urand(6));
            end
        end
        if (eu_valid_i) begin
            answered[eu_res_i.rob_idx] = 1'b1;
            resolve(int'(eu_res_i.rob_idx), eu_res_i.result);
        end
        if (cdb_valid_i) begin
            ext_pend[cdb_data_i.rob_idx] = 1'b0;
            resolve(int'(cdb_data_i.rob_idx), cdb_data_i.res_value);
        end
        if (cdb_valid_o && cdb_ready_i) begin
            t = int'(cdb_data_o.rob_idx);
            n_chk[3]++;
            if (!in_flight[t] || !answered[t]) begin
                report_failure(3, "CDB removal of a tag that is not in flight or has no result");
            end else begin
                cmp(3, "cdb_data_o.res_value", cdb_data_o.res_value, res_val[t]);
                cmp(3, "cdb_data_o.except_raised", 32'(cdb_data_o.except_raised),
                    32'(res_exc[t]));
                cmp(3, "cdb_data_o.except_code", 32'(cdb_data_o.except_code),
                    32'(res_code[t]));
                in_flight[t] = 1'b0;
            end
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("Timeout: the station did not drain all instructions in time");
        $display("test failed");
        $finish;
    end

    initial begin
        string names [1:6];
        int    total;
        names = '{"reset outputs", "dispatch operands", "cdb removals",
                  "issue_ready full flag", "cdb back-pressure", "flush"};
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_ctl_i = '0;
        issue_rs1_i = '0;
        issue_rs2_i = '0;
        issue_dest_i = '0;
        eu_ready_i = 1'b0;
        eu_valid_i = 1'b0;
        eu_res_i = '0;
        cdb_valid_i = 1'b0;
        cdb_data_i = '0;
        cdb_ready_i = 1'b0;
        for (int b = 1; b <= 6; b++) begin
            n_chk[b] = 0;
            n_err[b] = 0;
        end
        repeat (8) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        @(negedge clk_i);
        cmp(1, "eu_valid_o", 32'(eu_valid_o), 32'd0);
        cmp(1, "cdb_valid_o", 32'(cdb_valid_o), 32'd0);
        cmp(1, "issue_ready_o", 32'(issue_ready_o), 32'd1);
        while (issued < NUM_OPS || count_in_flight() > 0 || eu_tag_q.size() > 0
               || eu_valid_o || cdb_valid_o) begin
            if (!flushed && issued >= NUM_OPS / 2) begin
                flush_now = 1'b1;
                flushed   = 1'b1;
            end
            @(posedge clk_i);
            #2;
            drive_inputs();
            @(negedge clk_i);
            observe();
            cycle++;
        end
        total = 0;
        for (int b = 1; b <= 6; b++) begin
            $display("behavior %0d %s checks %0d errors %0d",
                     b, names[b], n_chk[b], n_err[b]);
            total += n_err[b];
        end
        $display("Totals: %0d issued, %0d cycles, %0d errors", issued, cycle, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/arith_rs_pkg.sv
verilog/prio_enc.sv
verilog/rs_entry.sv
verilog/arith_rs.sv
sim/arith_rs_props.sv
sim/tb_arith_rs.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_arith_rs \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
